// File: common/mam_pkg.sv
`default_nettype none

package mam_pkg;

  //////////////////////////////
  // AHB3 bus codes
  //////////////////////////////

  // Transfer type, only single transfers are issued
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // Transfer size, bytes per beat
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Slave response
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////
  // Arbiter
  //////////////////////////////

  // Owner of the shared memory bus
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'd0,
    ARB_ACCESS_MAM = 2'd1,
    ARB_ACCESS_CPU = 2'd2
  } arb_state_t;

endpackage

`default_nettype wire

// File: common/ahb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ahb_if #(
  parameter int PLEN = 32,
  parameter int XLEN = 32
);

  // Address phase, driven by the master
  logic              hsel;
  logic [PLEN-1:0]   haddr;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [2:0]        hburst;
  logic [XLEN/8-1:0] hprot;
  logic [1:0]        htrans;
  // Held high for the whole locked sequence
  logic              hmastlock;

  // Data phase
  logic [XLEN-1:0]   hwdata;
  logic [XLEN-1:0]   hrdata;
  // Completion and back-pressure
  logic              hready;
  logic              hresp;

  modport master (
    output hsel, haddr, hwdata, hwrite, hsize, hburst, hprot, htrans, hmastlock,
    input  hrdata, hready, hresp
  );

  modport slave (
    input  hsel, haddr, hwdata, hwrite, hsize, hburst, hprot, htrans, hmastlock,
    output hrdata, hready, hresp
  );

endinterface

`default_nettype wire

// File: logic/ahb_sram.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_sram #(
  parameter int PLEN      = 32,
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
) (
  input logic  biu_in_clk_i,
  input logic  biu_in_rst_i,
  ahb_if.slave bus
);
  import mam_pkg::*;

  localparam int SW      = XLEN / 8;
  localparam int BYTE_AW = $clog2(SW);
  localparam int WORD_AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0]    mem [MEM_WORDS];
  // Data phase in progress, and its second cycle
  logic               busy_q;
  logic               last_q;
  logic               accept;
  logic               oor;
  logic [WORD_AW-1:0] word_q;
  logic [BYTE_AW-1:0] off_q;
  logic [2:0]         size_q;
  logic               write_q;
  logic               oor_q;
  logic [SW-1:0]      lanes;
  logic [XLEN-1:0]    rdata_q;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  assign accept = bus.hsel && bus.hready && (bus.htrans == HTRANS_NONSEQ);
  // Word index at or past the end of the array
  assign oor    = (bus.haddr >> BYTE_AW) >= PLEN'(MEM_WORDS);

  // One wait cycle, then the completing cycle
  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      busy_q <= 1'b0;
      last_q <= 1'b0;
    end else if (bus.hready) begin
      busy_q <= accept;
      last_q <= 1'b0;
    end else begin
      last_q <= 1'b1;
    end
  end

  always_ff @(posedge biu_in_clk_i) begin
    if (accept) begin
      word_q  <= bus.haddr[BYTE_AW +: WORD_AW];
      off_q   <= bus.haddr[BYTE_AW-1:0];
      size_q  <= bus.hsize;
      write_q <= bus.hwrite;
      oor_q   <= oor;
    end
  end

  //////////////////////////////
  // Data phase
  //////////////////////////////

  // Byte lanes from size and offset, aligned accesses only
  always_comb begin
    case (size_q)
      HSIZE_BYTE: lanes = SW'(1) << off_q;
      HSIZE_HALF: lanes = SW'(3) << off_q;
      default:    lanes = '1;
    endcase
  end

  // Read in the wait cycle, so an earlier write is already in
  always_ff @(posedge biu_in_clk_i) begin
    if (busy_q && !last_q) begin
      rdata_q <= mem[word_q];
    end
    if (busy_q && last_q && write_q && !oor_q) begin
      for (int i = 0; i < SW; i++) begin
        if (lanes[i]) begin
          mem[word_q][8*i +: 8] <= bus.hwdata[8*i +: 8];
        end
      end
    end
  end

  assign bus.hready = !busy_q || last_q;
  // ERROR spans both cycles of the data phase
  assign bus.hresp  = (busy_q && oor_q) ? HRESP_ERROR : HRESP_OKAY;
  assign bus.hrdata = (busy_q && last_q && !write_q && !oor_q) ? rdata_q : '0;

endmodule

`default_nettype wire

// File: mam_adapter/mam_ahb_request.sv
`timescale 1ns/10ps
`default_nettype none

module mam_ahb_request #(
  parameter int PLEN = 32,
  parameter int XLEN = 32
) (
  input  logic            biu_in_clk_i,
  input  logic            biu_in_rst_i,
  // Single access request, data on its AHB byte lanes
  input  logic            mam_req_i,
  input  logic            mam_we_i,
  input  logic [PLEN-1:0] mam_addr_i,
  input  logic [2:0]      mam_size_i,
  input  logic [XLEN-1:0] mam_wdata_i,
  // Result, rdata and err valid with done
  output logic            mam_done_o,
  output logic [XLEN-1:0] mam_rdata_o,
  output logic            mam_err_o,
  ahb_if.master           bus
);
  import mam_pkg::*;

  localparam logic [1:0] REQ_IDLE = 2'd0;
  localparam logic [1:0] REQ_ADDR = 2'd1;
  localparam logic [1:0] REQ_DATA = 2'd2;

  logic [1:0]      state_q;
  logic            done_q;
  logic            we_q;
  logic [PLEN-1:0] addr_q;
  logic [2:0]      size_q;
  logic [XLEN-1:0] wdata_q;
  logic [XLEN-1:0] rdata_q;
  logic            err_q;

  //////////////////////////////
  // Transfer FSM
  //////////////////////////////

  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      state_q <= REQ_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        // Requests while busy are dropped here
        REQ_IDLE: begin
          if (mam_req_i) begin
            state_q <= REQ_ADDR;
          end
        end
        // Hold the address phase until the memory takes it
        REQ_ADDR: begin
          if (bus.hready) begin
            state_q <= REQ_DATA;
          end
        end
        // Data phase ends, lock falls with done
        REQ_DATA: begin
          if (bus.hready) begin
            state_q <= REQ_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: begin
          state_q <= REQ_IDLE;
        end
      endcase
    end
  end

  // Request latch and result capture
  always_ff @(posedge biu_in_clk_i) begin
    if (state_q == REQ_IDLE && mam_req_i) begin
      we_q    <= mam_we_i;
      addr_q  <= mam_addr_i;
      size_q  <= mam_size_i;
      wdata_q <= mam_wdata_i;
    end
    if (state_q == REQ_DATA && bus.hready) begin
      rdata_q <= bus.hrdata;
      err_q   <= (bus.hresp == HRESP_ERROR);
    end
  end

  //////////////////////////////
  // Bus drive
  //////////////////////////////

  assign bus.hsel      = (state_q == REQ_ADDR);
  assign bus.haddr     = addr_q;
  assign bus.hwrite    = we_q;
  assign bus.hsize     = size_q;
  // Single burst, data access
  assign bus.hburst    = 3'b000;
  assign bus.hprot     = {{(XLEN/8-1){1'b0}}, 1'b1};
  assign bus.htrans    = (state_q == REQ_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign bus.hmastlock = (state_q != REQ_IDLE);
  // Write data one cycle behind its address
  assign bus.hwdata    = (state_q == REQ_DATA) ? wdata_q : '0;

  assign mam_done_o  = done_q;
  assign mam_rdata_o = rdata_q;
  assign mam_err_o   = err_q;

endmodule

`default_nettype wire

// File: mam_adapter/mam_adapter_biu.sv
`timescale 1ns/10ps
`default_nettype none

module mam_adapter_biu #(
  parameter int PLEN = 32,
  parameter int XLEN = 32
) (
  input logic   biu_in_clk_i,
  input logic   biu_in_rst_i,
  // CPU side
  ahb_if.slave  cpu_bus,
  // Debug MAM side
  ahb_if.slave  mam_bus,
  // Shared memory
  ahb_if.master mem_bus
);
  import mam_pkg::*;

  // Quiet address driven while the owner is held off
  localparam logic [PLEN-1:0] ADDR_IDLE = '0;

  arb_state_t arb_state_q;
  arb_state_t arb_state_d;
  // Registered owner select, 1 = CPU
  logic       owner_cpu_q;
  logic       grant_cpu;
  logic       grant_mam;

  //////////////////////////////
  // Arbiter FSM
  //////////////////////////////

  // Lock levels drive the state, MAM wins from idle
  always_comb begin
    arb_state_d = ARB_IDLE;
    case (arb_state_q)
      ARB_IDLE: begin
        if (mam_bus.hmastlock) begin
          arb_state_d = ARB_ACCESS_MAM;
        end else if (cpu_bus.hmastlock) begin
          arb_state_d = ARB_ACCESS_CPU;
        end
      end
      ARB_ACCESS_MAM: begin
        if (mam_bus.hmastlock) begin
          arb_state_d = ARB_ACCESS_MAM;
        end
      end
      ARB_ACCESS_CPU: begin
        // A locked CPU sequence runs to its end first
        if (cpu_bus.hmastlock) begin
          arb_state_d = ARB_ACCESS_CPU;
        end else if (mam_bus.hmastlock) begin
          arb_state_d = ARB_ACCESS_MAM;
        end
      end
      default: begin
        arb_state_d = ARB_IDLE;
      end
    endcase
  end

  // Owner follows the state one edge later and holds through idle
  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      arb_state_q <= ARB_IDLE;
      owner_cpu_q <= 1'b0;
    end else begin
      arb_state_q <= arb_state_d;
      if (arb_state_q == ARB_ACCESS_CPU) begin
        owner_cpu_q <= 1'b1;
      end else if (arb_state_q == ARB_ACCESS_MAM) begin
        owner_cpu_q <= 1'b0;
      end
    end
  end

  // Path is open only while owner and state agree
  // keeps a new address phase off the bus during a handover
  assign grant_cpu = owner_cpu_q && (arb_state_q == ARB_ACCESS_CPU);
  assign grant_mam = !owner_cpu_q && (arb_state_q == ARB_ACCESS_MAM);

  //////////////////////////////
  // Request multiplexer
  //////////////////////////////

  always_comb begin
    if (owner_cpu_q) begin
      mem_bus.hsel      = cpu_bus.hsel & grant_cpu;
      mem_bus.haddr     = grant_cpu ? cpu_bus.haddr : ADDR_IDLE;
      mem_bus.htrans    = grant_cpu ? cpu_bus.htrans : HTRANS_IDLE;
      mem_bus.hwdata    = cpu_bus.hwdata;
      mem_bus.hwrite    = cpu_bus.hwrite;
      mem_bus.hsize     = cpu_bus.hsize;
      mem_bus.hburst    = cpu_bus.hburst;
      mem_bus.hprot     = cpu_bus.hprot;
      mem_bus.hmastlock = cpu_bus.hmastlock;
    end else begin
      mem_bus.hsel      = mam_bus.hsel & grant_mam;
      mem_bus.haddr     = grant_mam ? mam_bus.haddr : ADDR_IDLE;
      mem_bus.htrans    = grant_mam ? mam_bus.htrans : HTRANS_IDLE;
      mem_bus.hwdata    = mam_bus.hwdata;
      mem_bus.hwrite    = mam_bus.hwrite;
      mem_bus.hsize     = mam_bus.hsize;
      mem_bus.hburst    = mam_bus.hburst;
      mem_bus.hprot     = mam_bus.hprot;
      mem_bus.hmastlock = mam_bus.hmastlock;
    end
  end

  //////////////////////////////
  // Response routing
  //////////////////////////////

  // Waiting master sees hready low until its grant
  assign cpu_bus.hrdata = grant_cpu ? mem_bus.hrdata : {XLEN{1'b0}};
  assign cpu_bus.hready = grant_cpu & mem_bus.hready;
  assign cpu_bus.hresp  = grant_cpu ? mem_bus.hresp : HRESP_OKAY;

  assign mam_bus.hrdata = grant_mam ? mem_bus.hrdata : {XLEN{1'b0}};
  assign mam_bus.hready = grant_mam & mem_bus.hready;
  assign mam_bus.hresp  = grant_mam ? mem_bus.hresp : HRESP_OKAY;

endmodule

`default_nettype wire

// File: logic/mam_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module mam_soc_top #(
  parameter int PLEN      = 32,
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
) (
  input  logic              biu_in_clk_i,
  input  logic              biu_in_rst_i,
  // CPU AHB3 master
  input  logic              cpu_hsel_i,
  input  logic [PLEN-1:0]   cpu_haddr_i,
  input  logic [XLEN-1:0]   cpu_hwdata_i,
  input  logic              cpu_hwrite_i,
  input  logic [2:0]        cpu_hsize_i,
  input  logic [2:0]        cpu_hburst_i,
  input  logic [XLEN/8-1:0] cpu_hprot_i,
  input  logic [1:0]        cpu_htrans_i,
  input  logic              cpu_hmastlock_i,
  output logic [XLEN-1:0]   cpu_hrdata_o,
  output logic              cpu_hready_o,
  output logic              cpu_hresp_o,
  // Debug MAM requests
  input  logic              mam_req_i,
  input  logic              mam_we_i,
  input  logic [PLEN-1:0]   mam_addr_i,
  input  logic [2:0]        mam_size_i,
  input  logic [XLEN-1:0]   mam_wdata_i,
  output logic              mam_done_o,
  output logic [XLEN-1:0]   mam_rdata_o,
  output logic              mam_err_o
);

  ahb_if #(.PLEN(PLEN), .XLEN(XLEN)) cpu_bus ();
  ahb_if #(.PLEN(PLEN), .XLEN(XLEN)) mam_bus ();
  ahb_if #(.PLEN(PLEN), .XLEN(XLEN)) mem_bus ();

  //////////////////////////////
  // CPU port onto its bus
  //////////////////////////////

  assign cpu_bus.hsel      = cpu_hsel_i;
  assign cpu_bus.haddr     = cpu_haddr_i;
  assign cpu_bus.hwdata    = cpu_hwdata_i;
  assign cpu_bus.hwrite    = cpu_hwrite_i;
  assign cpu_bus.hsize     = cpu_hsize_i;
  assign cpu_bus.hburst    = cpu_hburst_i;
  assign cpu_bus.hprot     = cpu_hprot_i;
  assign cpu_bus.htrans    = cpu_htrans_i;
  assign cpu_bus.hmastlock = cpu_hmastlock_i;
  assign cpu_hrdata_o      = cpu_bus.hrdata;
  assign cpu_hready_o      = cpu_bus.hready;
  assign cpu_hresp_o       = cpu_bus.hresp;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  // MAM requests become locked single transfers
  mam_ahb_request #(
    .PLEN(PLEN),
    .XLEN(XLEN)
  ) mam_ahb_request_inst (
    .biu_in_clk_i(biu_in_clk_i),
    .biu_in_rst_i(biu_in_rst_i),
    .mam_req_i   (mam_req_i),
    .mam_we_i    (mam_we_i),
    .mam_addr_i  (mam_addr_i),
    .mam_size_i  (mam_size_i),
    .mam_wdata_i (mam_wdata_i),
    .mam_done_o  (mam_done_o),
    .mam_rdata_o (mam_rdata_o),
    .mam_err_o   (mam_err_o),
    .bus         (mam_bus.master)
  );

  // Arbiter, MAM first
  mam_adapter_biu #(
    .PLEN(PLEN),
    .XLEN(XLEN)
  ) mam_adapter_biu_inst (
    .biu_in_clk_i(biu_in_clk_i),
    .biu_in_rst_i(biu_in_rst_i),
    .cpu_bus     (cpu_bus.slave),
    .mam_bus     (mam_bus.slave),
    .mem_bus     (mem_bus.master)
  );

  ahb_sram #(
    .PLEN     (PLEN),
    .XLEN     (XLEN),
    .MEM_WORDS(MEM_WORDS)
  ) ahb_sram_inst (
    .biu_in_clk_i(biu_in_clk_i),
    .biu_in_rst_i(biu_in_rst_i),
    .bus         (mem_bus.slave)
  );

endmodule

`default_nettype wire

// File: verification/mam_soc_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mam_soc_asserts (
  input logic                clk_i,
  input logic                rst_i,
  input mam_pkg::arb_state_t arb_state_i,
  input logic                owner_cpu_i,
  input logic                cpu_hready_i,
  input logic                cpu_hresp_i,
  input logic                mam_hready_i,
  input logic                mam_hresp_i,
  input logic                mam_lock_i
);
  import mam_pkg::*;

  // Only one master can see a completing cycle
  hready_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cpu_hready_i && mam_hready_i)) else $error("both masters saw hready");

  state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    arb_state_i inside {ARB_IDLE, ARB_ACCESS_MAM, ARB_ACCESS_CPU})
    else $error("arbiter state out of range");

  // Response of the master that does not own the bus
  nonowner_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    owner_cpu_i ? !mam_hresp_i : !cpu_hresp_i) else $error("hresp leaked to non-owner");

  // A granted MAM keeps the bus for its whole lock
  mam_keeps_bus: assert property (@(posedge clk_i) disable iff (rst_i)
    (!owner_cpu_i && arb_state_i == ARB_ACCESS_MAM && mam_lock_i) |=>
    (arb_state_i == ARB_ACCESS_MAM && !owner_cpu_i))
    else $error("MAM lost the bus while locked");

endmodule

bind mam_adapter_biu mam_soc_asserts mam_soc_asserts_inst (
  .clk_i       (biu_in_clk_i),
  .rst_i       (biu_in_rst_i),
  .arb_state_i (arb_state_q),
  .owner_cpu_i (owner_cpu_q),
  .cpu_hready_i(cpu_bus.hready),
  .cpu_hresp_i (cpu_bus.hresp),
  .mam_hready_i(mam_bus.hready),
  .mam_hresp_i (mam_bus.hresp),
  .mam_lock_i  (mam_bus.hmastlock)
);

`default_nettype wire

// File: verification/mam_soc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mam_soc_tb;

  // About 90 transfers of up to 12 cycles each leave a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MEM_WORDS = 256;

  logic        biu_in_clk;
  logic        biu_in_rst;
  logic        cpu_hsel;
  logic [31:0] cpu_haddr;
  logic [31:0] cpu_hwdata;
  logic        cpu_hwrite;
  logic [2:0]  cpu_hsize;
  logic [2:0]  cpu_hburst;
  logic [3:0]  cpu_hprot;
  logic [1:0]  cpu_htrans;
  logic        cpu_hmastlock;
  logic [31:0] cpu_hrdata;
  logic        cpu_hready;
  logic        cpu_hresp;
  logic        mam_req;
  logic        mam_we;
  logic [31:0] mam_addr;
  logic [2:0]  mam_size;
  logic [31:0] mam_wdata;
  logic        mam_done;
  logic [31:0] mam_rdata;
  logic        mam_err;

  // Reference copy of the memory
  logic [31:0] ref_mem [MEM_WORDS];
  int          errors;
  int          checks;
  int          cycles;
  time         cpu_done_t;
  time         mam_done_t;

  mam_soc_top #(
    .PLEN     (32),
    .XLEN     (32),
    .MEM_WORDS(MEM_WORDS)
  ) mam_soc_top_inst (
    .biu_in_clk_i   (biu_in_clk),
    .biu_in_rst_i   (biu_in_rst),
    .cpu_hsel_i     (cpu_hsel),
    .cpu_haddr_i    (cpu_haddr),
    .cpu_hwdata_i   (cpu_hwdata),
    .cpu_hwrite_i   (cpu_hwrite),
    .cpu_hsize_i    (cpu_hsize),
    .cpu_hburst_i   (cpu_hburst),
    .cpu_hprot_i    (cpu_hprot),
    .cpu_htrans_i   (cpu_htrans),
    .cpu_hmastlock_i(cpu_hmastlock),
    .cpu_hrdata_o   (cpu_hrdata),
    .cpu_hready_o   (cpu_hready),
    .cpu_hresp_o    (cpu_hresp),
    .mam_req_i      (mam_req),
    .mam_we_i       (mam_we),
    .mam_addr_i     (mam_addr),
    .mam_size_i     (mam_size),
    .mam_wdata_i    (mam_wdata),
    .mam_done_o     (mam_done),
    .mam_rdata_o    (mam_rdata),
    .mam_err_o      (mam_err)
  );

  initial begin
    biu_in_clk = 1'b0;
    forever #10 biu_in_clk = ~biu_in_clk;
  end

  // Hang guard
  always @(posedge biu_in_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a ready or done never arrived", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Byte lanes picked by size and low address bits
  task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
    logic [3:0] lanes;
    case (size)
      3'd0: lanes = 4'b0001 << addr[1:0];
      3'd1: lanes = 4'b0011 << addr[1:0];
      default: lanes = 4'b1111;
    endcase
    if (addr[31:2] < MEM_WORDS) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          ref_mem[addr[31:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endtask

  //////////////////////////////
  // CPU master
  //////////////////////////////

  task automatic cpu_wait_ready();
    @(negedge biu_in_clk);
    while (!cpu_hready) begin
      @(negedge biu_in_clk);
    end
  endtask

  // One address phase and its data phase under a lock that is already high
  task automatic cpu_xfer(input logic we, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic resp);
    cpu_hsel   = 1'b1;
    cpu_haddr  = addr;
    cpu_hwrite = we;
    cpu_hsize  = size;
    cpu_htrans = 2'b10;
    cpu_wait_ready();
    @(posedge biu_in_clk);
    #2;
    cpu_hsel   = 1'b0;
    cpu_htrans = 2'b00;
    cpu_hwdata = wdata;
    cpu_wait_ready();
    rdata = cpu_hrdata;
    resp  = cpu_hresp;
    @(posedge biu_in_clk);
    cpu_done_t = $time;
    #2;
  endtask

  task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic resp);
    cpu_hmastlock = 1'b1;
    cpu_xfer(we, addr, size, wdata, rdata, resp);
    cpu_hmastlock = 1'b0;
  endtask

  task automatic cpu_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    logic [31:0] rdata;
    logic        resp;
    cpu_access(1'b1, addr, size, data, rdata, resp);
    check_value("cpu_hresp_o", resp, 0);
    model_write(addr, size, data);
  endtask

  task automatic cpu_read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    logic        resp;
    cpu_access(1'b0, addr, 3'd2, 32'h0, rdata, resp);
    check_value("cpu_hresp_o", resp, 0);
    check_value("cpu_hrdata_o", rdata, ref_mem[addr[31:2]]);
  endtask

  //////////////////////////////
  // MAM requests
  //////////////////////////////

  task automatic mam_access(input logic we, input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    mam_req   = 1'b1;
    mam_we    = we;
    mam_addr  = addr;
    mam_size  = size;
    mam_wdata = wdata;
    @(posedge biu_in_clk);
    #2;
    mam_req = 1'b0;
    @(negedge biu_in_clk);
    while (!mam_done) begin
      @(negedge biu_in_clk);
    end
    rdata = mam_rdata;
    err   = mam_err;
    @(posedge biu_in_clk);
    mam_done_t = $time;
    #2;
  endtask

  task automatic mam_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    mam_access(1'b1, addr, size, data, rdata, err);
    check_value("mam_err_o", err, 0);
    model_write(addr, size, data);
  endtask

  task automatic mam_read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    mam_access(1'b0, addr, 3'd2, 32'h0, rdata, err);
    check_value("mam_err_o", err, 0);
    check_value("mam_rdata_o", rdata, ref_mem[addr[31:2]]);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge biu_in_clk);
    check_value("cpu_hready_o", cpu_hready, 0);
    check_value("mam_done_o", mam_done, 0);
    check_value("cpu_hresp_o", cpu_hresp, 0);
    @(posedge biu_in_clk);
    #2;
  endtask

  task automatic test_cpu_lanes();
    cpu_write(32'h10, 3'd2, 32'h1122_3344);
    cpu_write(32'h12, 3'd1, 32'hAABB_0000);
    cpu_write(32'h11, 3'd0, 32'h0000_CC00);
    cpu_read_check(32'h10);
    cpu_write(32'h14, 3'd2, 32'h5566_7788);
    cpu_write(32'h17, 3'd0, 32'hEE00_0000);
    cpu_write(32'h14, 3'd1, 32'h0000_DDDD);
    cpu_read_check(32'h14);
  endtask

  task automatic test_shared_memory();
    mam_write(32'h20, 3'd2, 32'hCAFE_F00D);
    cpu_read_check(32'h20);
    cpu_write(32'h24, 3'd2, 32'h0BAD_BEEF);
    mam_read_check(32'h24);
    mam_write(32'h26, 3'd1, 32'h1234_0000);
    cpu_read_check(32'h24);
  endtask

  task automatic test_priority();
    logic [31:0] rdata;
    logic        resp;
    // Both locks rise together from idle
    fork
      mam_write(32'h30, 3'd2, 32'h0000_0A0A);
      begin
        @(posedge biu_in_clk);
        #2;
        cpu_write(32'h34, 3'd2, 32'h0000_0B0B);
      end
    join
    checks++;
    assert (mam_done_t < cpu_done_t) else begin
      errors++;
      $display("MAM did not finish before the CPU when both locked from idle");
    end
    // A locked CPU sequence finishes before a later MAM request
    fork
      begin
        cpu_hmastlock = 1'b1;
        for (int i = 0; i < 3; i++) begin
          cpu_xfer(1'b1, 32'h40 + 4 * i, 3'd2, 32'h100 + i, rdata, resp);
          check_value("cpu_hresp_o", resp, 0);
          model_write(32'h40 + 4 * i, 3'd2, 32'h100 + i);
        end
        cpu_hmastlock = 1'b0;
      end
      begin
        repeat (3) @(posedge biu_in_clk);
        #2;
        mam_write(32'h40, 3'd2, 32'h0000_0D0D);
      end
    join
    checks++;
    assert (mam_done_t > cpu_done_t) else begin
      errors++;
      $display("MAM request completed inside a locked CPU sequence");
    end
    mam_read_check(32'h40);
    cpu_read_check(32'h44);
    cpu_read_check(32'h30);
  endtask

  task automatic test_error_response();
    logic [31:0] rdata;
    logic        resp;
    logic        err;
    cpu_write(32'h0, 3'd2, 32'h1357_9BDF);
    mam_write(32'h4, 3'd2, 32'h2468_ACE0);
    // Out-of-range words alias words 0 and 1 in the index bits
    cpu_access(1'b1, MEM_WORDS * 4, 3'd2, 32'hFFFF_FFFF, rdata, resp);
    check_value("cpu_hresp_o", resp, 1);
    cpu_access(1'b0, MEM_WORDS * 4 + 8, 3'd2, 32'h0, rdata, resp);
    check_value("cpu_hresp_o", resp, 1);
    mam_access(1'b1, MEM_WORDS * 4 + 4, 3'd2, 32'hFFFF_FFFF, rdata, err);
    check_value("mam_err_o", err, 1);
    cpu_read_check(32'h0);
    mam_read_check(32'h4);
  endtask

  task automatic test_random();
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] data;
    for (int w = 0; w < 16; w++) begin
      cpu_write(32'h80 + 4 * w, 3'd2, $urandom);
    end
    for (int i = 0; i < 40; i++) begin
      size = 3'($urandom_range(0, 2));
      addr = 32'h80 + 4 * $urandom_range(0, 15);
      if (size == 3'd0) begin
        addr[1:0] = 2'($urandom_range(0, 3));
      end else if (size == 3'd1) begin
        addr[1] = 1'($urandom_range(0, 1));
      end
      data = $urandom;
      if ($urandom_range(0, 1) == 1) begin
        if (i % 2 == 0) begin
          cpu_write(addr, size, data);
        end else begin
          mam_write(addr, size, data);
        end
      end else begin
        // Word reads use the aligned word address
        if (i % 2 == 0) begin
          cpu_read_check({addr[31:2], 2'b00});
        end else begin
          mam_read_check({addr[31:2], 2'b00});
        end
      end
    end
  endtask

  //////////////////////////////
  // Run
  //////////////////////////////

  initial begin
    void'($urandom(72));
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    biu_in_rst    = 1'b1;
    cpu_hsel      = 1'b0;
    cpu_haddr     = '0;
    cpu_hwdata    = '0;
    cpu_hwrite    = 1'b0;
    cpu_hsize     = 3'd2;
    cpu_hburst    = 3'd0;
    cpu_hprot     = 4'd1;
    cpu_htrans    = 2'b00;
    cpu_hmastlock = 1'b0;
    mam_req       = 1'b0;
    mam_we        = 1'b0;
    mam_addr      = '0;
    mam_size      = 3'd2;
    mam_wdata     = '0;
    repeat (8) @(posedge biu_in_clk);
    #2;
    biu_in_rst = 1'b0;
    test_reset_state();
    test_cpu_lanes();
    test_shared_memory();
    test_priority();
    test_error_response();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
common/mam_pkg.sv
common/ahb_if.sv
logic/ahb_sram.sv
mam_adapter/mam_ahb_request.sv
mam_adapter/mam_adapter_biu.sv
logic/mam_soc_top.sv
verification/mam_soc_asserts.sv
verification/mam_soc_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module mam_soc_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module mam_soc_tb -Mdir obj_dir
	./obj_dir/Vmam_soc_tb | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
